// File: design/lsq_pkg.sv
package lsq_pkg;

	// data and address width
	localparam int XLEN = 32;

	// width of the load destination tag
	localparam int TAG_W = 6;

	typedef enum logic [1:0] {
		BYTE = 2'd0,
		HALF = 2'd1,
		WORD = 2'd2
	} mem_size_t;

	// pick byte, half or word out of a word and extend it
	function automatic logic [XLEN-1:0] load_extract(
		input logic [XLEN-1:0] word,
		input logic [1:0] offset,
		input mem_size_t size,
		input logic is_unsigned
	);
		logic [XLEN-1:0] shifted;
		logic [XLEN-1:0] result;
		shifted = word >> {offset, 3'b000};
		case (size)
			BYTE: result = is_unsigned ? {{(XLEN-8){1'b0}}, shifted[7:0]} :
				{{(XLEN-8){shifted[7]}}, shifted[7:0]};
			HALF: result = is_unsigned ? {{(XLEN-16){1'b0}}, shifted[15:0]} :
				{{(XLEN-16){shifted[15]}}, shifted[15:0]};
			default: result = word;
		endcase
		return result;
	endfunction

endpackage

// File: design/store_credit.sv
`timescale 1ns/1ps

// counts free store queue entries for the dispatcher
module store_credit #(
	parameter int N_WAY = 2,
	parameter int N_SQ = 8
) (
	input logic clock,
	input logic reset,
	input logic [$clog2(N_WAY):0] disp_count,
	input logic [$clog2(N_SQ):0] freed,
	output logic [$clog2(N_SQ):0] credits
);

	localparam int KW = $clog2(N_SQ) + 1;

	logic [KW-1:0] credits_next;

	// returned entries come back while new stores take theirs away
	assign credits_next = credits + freed - KW'(disp_count);

	always_ff @(posedge clock) begin
		if (reset) begin
			// the whole queue is free after reset
			credits <= KW'(N_SQ);
		end else begin
			credits <= credits_next;
		end
	end

endmodule

// File: design/store_queue.sv
`timescale 1ns/1ps

// circular store queue, entries leave at the head in program order
module store_queue #(
	parameter int N_WAY = 2,
	parameter int N_SQ = 8
) (
	input logic clock,
	input logic reset,
	input logic [$clog2(N_WAY):0] disp_count,
	input logic [N_WAY-1:0] ex_valid,
	input logic [N_WAY-1:0][$clog2(N_SQ)-1:0] ex_pos,
	input logic [N_WAY-1:0][lsq_pkg::XLEN-1:0] ex_addr,
	input logic [N_WAY-1:0][lsq_pkg::XLEN-1:0] ex_data,
	input lsq_pkg::mem_size_t [N_WAY-1:0] ex_size,
	input logic [$clog2(N_WAY):0] retire_count,
	input logic flush,
	output logic [$clog2(N_SQ)-1:0] alloc_pos,
	output logic [$clog2(N_SQ)-1:0] head,
	output logic [N_SQ-1:0] ent_valid,
	output logic [N_SQ-1:0] ent_ex,
	output logic [N_SQ-1:0][lsq_pkg::XLEN-1:0] ent_addr,
	output logic [N_SQ-1:0][lsq_pkg::XLEN-1:0] ent_data,
	output lsq_pkg::mem_size_t [N_SQ-1:0] ent_size,
	output logic [N_WAY-1:0] wr_valid,
	output logic [N_WAY-1:0][lsq_pkg::XLEN-1:0] wr_addr,
	output logic [N_WAY-1:0][lsq_pkg::XLEN-1:0] wr_data,
	output lsq_pkg::mem_size_t [N_WAY-1:0] wr_size,
	output logic [$clog2(N_SQ):0] freed
);

	localparam int IW = $clog2(N_SQ);
	localparam int CW = $clog2(N_WAY) + 1;

	logic [IW-1:0] tail;
	logic [IW-1:0] head_next;
	logic [IW:0] occupancy;
	logic [N_WAY-1:0][IW-1:0] ret_idx;
	logic [N_WAY-1:0][IW-1:0] disp_idx;

	// new stores are tagged with the current tail
	assign alloc_pos = tail;
	assign head_next = head + IW'(retire_count);

	// slots touched by retire and dispatch this cycle, wrapping around
	always_comb begin
		for (int i = 0; i < N_WAY; i++) begin
			ret_idx[i] = head + IW'(i);
			disp_idx[i] = tail + IW'(i);
		end
	end

	// number of live entries, needed to return credits on a flush
	always_comb begin
		occupancy = '0;
		for (int i = 0; i < N_SQ; i++) begin
			occupancy = occupancy + (IW+1)'(ent_valid[i]);
		end
	end

	// oldest retire_count entries go straight to the data memory
	always_comb begin
		for (int i = 0; i < N_WAY; i++) begin
			wr_valid[i] = CW'(i) < retire_count;
			wr_addr[i] = ent_addr[ret_idx[i]];
			wr_data[i] = ent_data[ret_idx[i]];
			wr_size[i] = ent_size[ret_idx[i]];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			ent_valid <= '0;
			ent_ex <= '0;
			freed <= '0;
		end else if (flush) begin
			// stores retiring now still reach memory, the rest are dropped
			head <= head_next;
			tail <= head_next;
			ent_valid <= '0;
			ent_ex <= '0;
			// stores dispatched in the flush cycle also give their credit back
			freed <= occupancy + (IW+1)'(disp_count);
		end else begin
			for (int i = 0; i < N_WAY; i++) begin
				if (CW'(i) < retire_count) begin
					ent_valid[ret_idx[i]] <= 1'b0;
					ent_ex[ret_idx[i]] <= 1'b0;
				end
			end
			for (int i = 0; i < N_WAY; i++) begin
				if (CW'(i) < disp_count) begin
					ent_valid[disp_idx[i]] <= 1'b1;
					ent_ex[disp_idx[i]] <= 1'b0;
				end
			end
			// execute results may arrive in any order
			for (int i = 0; i < N_WAY; i++) begin
				if (ex_valid[i]) begin
					ent_ex[ex_pos[i]] <= 1'b1;
				end
			end
			head <= head_next;
			tail <= tail + IW'(disp_count);
			freed <= (IW+1)'(retire_count);
		end
	end

	// address, data and size of each entry, filled at execute
	always_ff @(posedge clock) begin
		for (int i = 0; i < N_WAY; i++) begin
			if (ex_valid[i] && !flush) begin
				ent_addr[ex_pos[i]] <= ex_addr[i];
				ent_data[ex_pos[i]] <= ex_data[i];
				ent_size[ex_pos[i]] <= ex_size[i];
			end
		end
	end

endmodule

// File: design/store_forward.sv
`timescale 1ns/1ps

// finds the youngest older store that holds every byte of the load
module store_forward #(
	parameter int N_SQ = 8
) (
	input logic [$clog2(N_SQ)-1:0] head,
	input logic [N_SQ-1:0] ent_valid,
	input logic [N_SQ-1:0] ent_ex,
	input logic [N_SQ-1:0][lsq_pkg::XLEN-1:0] ent_addr,
	input logic [N_SQ-1:0][lsq_pkg::XLEN-1:0] ent_data,
	input lsq_pkg::mem_size_t [N_SQ-1:0] ent_size,
	input logic load_valid,
	input logic [lsq_pkg::XLEN-1:0] load_addr,
	input lsq_pkg::mem_size_t load_size,
	input logic load_unsigned,
	input logic [$clog2(N_SQ):0] load_older_count,
	output logic fwd_hit,
	output logic [lsq_pkg::XLEN-1:0] fwd_data
);

	localparam int IW = $clog2(N_SQ);
	localparam int XLEN = lsq_pkg::XLEN;

	logic [IW-1:0] idx;
	logic found;
	logic [XLEN-1:0] lane;

	// a store covers the load if it is at least as wide and aligned over it
	function automatic logic store_covers(
		input logic [XLEN-1:0] st_addr,
		input lsq_pkg::mem_size_t st_size,
		input logic [XLEN-1:0] ld_addr,
		input lsq_pkg::mem_size_t ld_size
	);
		logic hit;
		case (st_size)
			lsq_pkg::WORD: hit = st_addr[XLEN-1:2] == ld_addr[XLEN-1:2];
			lsq_pkg::HALF: hit = ld_size != lsq_pkg::WORD &&
				st_addr[XLEN-1:1] == ld_addr[XLEN-1:1];
			default: hit = ld_size == lsq_pkg::BYTE && st_addr == ld_addr;
		endcase
		return hit;
	endfunction

	always_comb begin
		found = 1'b0;
		lane = '0;
		idx = head;
		// walk from oldest to youngest, so the last match wins
		for (int k = 0; k < N_SQ; k++) begin
			idx = head + IW'(k);
			if ((IW+1)'(k) < load_older_count && ent_valid[idx] && ent_ex[idx] &&
				store_covers(ent_addr[idx], ent_size[idx], load_addr, load_size)) begin
				found = 1'b1;
				// move store bytes to their lanes in the memory word
				lane = ent_data[idx] << {ent_addr[idx][1:0], 3'b000};
			end
		end
	end

	assign fwd_hit = load_valid && found;
	assign fwd_data = lsq_pkg::load_extract(lane, load_addr[1:0], load_size, load_unsigned);

endmodule

// File: design/data_memory.sv
`timescale 1ns/1ps

// word memory with byte enables and the registered load result
module data_memory #(
	parameter int N_WAY = 2,
	parameter int MEM_WORDS = 64
) (
	input logic clock,
	input logic reset,
	input logic [N_WAY-1:0] wr_valid,
	input logic [N_WAY-1:0][lsq_pkg::XLEN-1:0] wr_addr,
	input logic [N_WAY-1:0][lsq_pkg::XLEN-1:0] wr_data,
	input lsq_pkg::mem_size_t [N_WAY-1:0] wr_size,
	input logic load_valid,
	input logic [lsq_pkg::XLEN-1:0] load_addr,
	input lsq_pkg::mem_size_t load_size,
	input logic load_unsigned,
	input logic [lsq_pkg::TAG_W-1:0] load_tag,
	input logic fwd_hit,
	input logic [lsq_pkg::XLEN-1:0] fwd_data,
	output logic result_valid,
	output logic [lsq_pkg::XLEN-1:0] result_data,
	output logic [lsq_pkg::TAG_W-1:0] result_tag,
	output logic result_forwarded
);

	localparam int AW = $clog2(MEM_WORDS);
	localparam int NB = lsq_pkg::XLEN / 8;

	logic [lsq_pkg::XLEN-1:0] mem [MEM_WORDS];
	logic [N_WAY-1:0][NB-1:0] wr_be;
	logic [N_WAY-1:0][lsq_pkg::XLEN-1:0] wr_lane;
	logic [lsq_pkg::XLEN-1:0] load_word;

	// byte enables and lane alignment per write port
	always_comb begin
		for (int i = 0; i < N_WAY; i++) begin
			case (wr_size[i])
				lsq_pkg::BYTE: wr_be[i] = NB'(4'b0001) << wr_addr[i][1:0];
				lsq_pkg::HALF: wr_be[i] = NB'(4'b0011) << wr_addr[i][1:0];
				default: wr_be[i] = '1;
			endcase
			wr_lane[i] = wr_data[i] << {wr_addr[i][1:0], 3'b000};
		end
	end

	assign load_word = mem[load_addr[AW+1:2]];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int w = 0; w < MEM_WORDS; w++) begin
				mem[w] <= '0;
			end
		end else begin
			// higher ways are younger, so they are written last
			for (int i = 0; i < N_WAY; i++) begin
				if (wr_valid[i]) begin
					for (int b = 0; b < NB; b++) begin
						if (wr_be[i][b]) begin
							mem[wr_addr[i][AW+1:2]][8*b +: 8] <= wr_lane[i][8*b +: 8];
						end
					end
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= load_valid;
		end
	end

	// memory is read before this edge's retire writes land
	// forwarding still sees those stores in the same cycle
	always_ff @(posedge clock) begin
		if (load_valid) begin
			result_tag <= load_tag;
			result_forwarded <= fwd_hit;
			result_data <= fwd_hit ? fwd_data :
				lsq_pkg::load_extract(load_word, load_addr[1:0], load_size, load_unsigned);
		end
	end

endmodule

// File: design/lsq_top.sv
`timescale 1ns/1ps

// store side of the load/store unit
module lsq_top #(
	parameter int N_WAY = 2,
	parameter int N_SQ = 8,
	parameter int MEM_WORDS = 64
) (
	input logic clock,
	input logic reset,
	input logic [$clog2(N_WAY):0] disp_count,
	output logic [$clog2(N_SQ)-1:0] alloc_pos,
	output logic [$clog2(N_SQ):0] credits,
	input logic [N_WAY-1:0] ex_valid,
	input logic [N_WAY-1:0][$clog2(N_SQ)-1:0] ex_pos,
	input logic [N_WAY-1:0][lsq_pkg::XLEN-1:0] ex_addr,
	input logic [N_WAY-1:0][lsq_pkg::XLEN-1:0] ex_data,
	input lsq_pkg::mem_size_t [N_WAY-1:0] ex_size,
	input logic [$clog2(N_WAY):0] retire_count,
	input logic flush,
	input logic load_valid,
	input logic [lsq_pkg::XLEN-1:0] load_addr,
	input lsq_pkg::mem_size_t load_size,
	input logic load_unsigned,
	input logic [lsq_pkg::TAG_W-1:0] load_tag,
	input logic [$clog2(N_SQ):0] load_older_count,
	output logic result_valid,
	output logic [lsq_pkg::XLEN-1:0] result_data,
	output logic [lsq_pkg::TAG_W-1:0] result_tag,
	output logic result_forwarded
);

	logic [$clog2(N_SQ):0] freed;
	logic [$clog2(N_SQ)-1:0] head;
	logic [N_SQ-1:0] ent_valid;
	logic [N_SQ-1:0] ent_ex;
	logic [N_SQ-1:0][lsq_pkg::XLEN-1:0] ent_addr;
	logic [N_SQ-1:0][lsq_pkg::XLEN-1:0] ent_data;
	lsq_pkg::mem_size_t [N_SQ-1:0] ent_size;
	logic [N_WAY-1:0] wr_valid;
	logic [N_WAY-1:0][lsq_pkg::XLEN-1:0] wr_addr;
	logic [N_WAY-1:0][lsq_pkg::XLEN-1:0] wr_data;
	lsq_pkg::mem_size_t [N_WAY-1:0] wr_size;
	logic fwd_hit;
	logic [lsq_pkg::XLEN-1:0] fwd_data;

	store_credit #(
		.N_WAY(N_WAY),
		.N_SQ(N_SQ)
	) store_credit_inst (
		.clock(clock),
		.reset(reset),
		.disp_count(disp_count),
		.freed(freed),
		.credits(credits)
	);

	store_queue #(
		.N_WAY(N_WAY),
		.N_SQ(N_SQ)
	) store_queue_inst (
		.clock(clock),
		.reset(reset),
		.disp_count(disp_count),
		.ex_valid(ex_valid),
		.ex_pos(ex_pos),
		.ex_addr(ex_addr),
		.ex_data(ex_data),
		.ex_size(ex_size),
		.retire_count(retire_count),
		.flush(flush),
		.alloc_pos(alloc_pos),
		.head(head),
		.ent_valid(ent_valid),
		.ent_ex(ent_ex),
		.ent_addr(ent_addr),
		.ent_data(ent_data),
		.ent_size(ent_size),
		.wr_valid(wr_valid),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_size(wr_size),
		.freed(freed)
	);

	store_forward #(
		.N_SQ(N_SQ)
	) store_forward_inst (
		.head(head),
		.ent_valid(ent_valid),
		.ent_ex(ent_ex),
		.ent_addr(ent_addr),
		.ent_data(ent_data),
		.ent_size(ent_size),
		.load_valid(load_valid),
		.load_addr(load_addr),
		.load_size(load_size),
		.load_unsigned(load_unsigned),
		.load_older_count(load_older_count),
		.fwd_hit(fwd_hit),
		.fwd_data(fwd_data)
	);

	data_memory #(
		.N_WAY(N_WAY),
		.MEM_WORDS(MEM_WORDS)
	) data_memory_inst (
		.clock(clock),
		.reset(reset),
		.wr_valid(wr_valid),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_size(wr_size),
		.load_valid(load_valid),
		.load_addr(load_addr),
		.load_size(load_size),
		.load_unsigned(load_unsigned),
		.load_tag(load_tag),
		.fwd_hit(fwd_hit),
		.fwd_data(fwd_data),
		.result_valid(result_valid),
		.result_data(result_data),
		.result_tag(result_tag),
		.result_forwarded(result_forwarded)
	);

endmodule

// File: tb/lsq_ref.svh
`ifndef LSQ_REF_SVH
`define LSQ_REF_SVH

// byte image of the data memory and a copy of the store queue entries
logic [7:0] ref_mem [MEM_WORDS*4];
logic m_valid [N_SQ];
logic m_ex [N_SQ];
logic [31:0] m_addr [N_SQ];
logic [31:0] m_data [N_SQ];
lsq_pkg::mem_size_t m_size [N_SQ];
int m_head;
int m_tail;
int m_count;

function automatic int size_bytes(input lsq_pkg::mem_size_t s);
	case (s)
		lsq_pkg::BYTE: return 1;
		lsq_pkg::HALF: return 2;
		default: return 4;
	endcase
endfunction

// entry p holds every byte of the access
function automatic logic store_holds(input int p, input int addr, input int len);
	int sa;
	sa = int'(m_addr[p]);
	return sa <= addr && addr + len <= sa + size_bytes(m_size[p]);
endfunction

function automatic logic store_touches(input int p, input int addr, input int len);
	int sa;
	sa = int'(m_addr[p]);
	return sa < addr + len && addr < sa + size_bytes(m_size[p]);
endfunction

// youngest older entry that is unknown or overlapping must cover the load
function automatic logic load_defined(input int addr, input lsq_pkg::mem_size_t size,
		input int older);
	int y;
	int p;
	y = -1;
	for (int k = 0; k < older; k++) begin
		p = (m_head + k) % N_SQ;
		if (m_valid[p] && (!m_ex[p] || store_touches(p, addr, size_bytes(size))))
			y = p;
	end
	return y < 0 || (m_ex[y] && store_holds(y, addr, size_bytes(size)));
endfunction

function automatic logic [31:0] expected_load(input int addr, input lsq_pkg::mem_size_t size,
		input logic uns, input int older, output logic fwd);
	logic [7:0] b [4];
	logic [31:0] sh;
	int len;
	int p;
	len = size_bytes(size);
	fwd = 1'b0;
	for (int j = 0; j < 4; j++)
		b[j] = (j < len) ? ref_mem[addr + j] : 8'h00;
	// oldest first, so the youngest covering store is applied last
	for (int k = 0; k < older; k++) begin
		p = (m_head + k) % N_SQ;
		if (m_valid[p] && m_ex[p] && store_holds(p, addr, len)) begin
			fwd = 1'b1;
			for (int j = 0; j < len; j++) begin
				sh = m_data[p] >> (8 * (addr + j - int'(m_addr[p])));
				b[j] = sh[7:0];
			end
		end
	end
	case (len)
		1: return uns ? {24'h0, b[0]} : {{24{b[0][7]}}, b[0]};
		2: return uns ? {16'h0, b[1], b[0]} : {{16{b[1][7]}}, b[1], b[0]};
		default: return {b[3], b[2], b[1], b[0]};
	endcase
endfunction

`endif

// File: tb/lsq_tb.sv
`timescale 1ns/1ps

module lsq_tb;

	localparam int N_WAY = 2;
	localparam int N_SQ = 8;
	localparam int MEM_WORDS = 64;
	localparam int XLEN = lsq_pkg::XLEN;

	logic clock;
	logic reset;
	logic [$clog2(N_WAY):0] disp_count;
	logic [$clog2(N_SQ)-1:0] alloc_pos;
	logic [$clog2(N_SQ):0] credits;
	logic [N_WAY-1:0] ex_valid;
	logic [N_WAY-1:0][$clog2(N_SQ)-1:0] ex_pos;
	logic [N_WAY-1:0][XLEN-1:0] ex_addr;
	logic [N_WAY-1:0][XLEN-1:0] ex_data;
	lsq_pkg::mem_size_t [N_WAY-1:0] ex_size;
	logic [$clog2(N_WAY):0] retire_count;
	logic flush;
	logic load_valid;
	logic [XLEN-1:0] load_addr;
	lsq_pkg::mem_size_t load_size;
	logic load_unsigned;
	logic [lsq_pkg::TAG_W-1:0] load_tag;
	logic [$clog2(N_SQ):0] load_older_count;
	logic result_valid;
	logic [XLEN-1:0] result_data;
	logic [lsq_pkg::TAG_W-1:0] result_tag;
	logic result_forwarded;

	`include "lsq_ref.svh"

	logic [XLEN-1:0] exp_data [$];
	logic exp_fwd [$];
	logic [lsq_pkg::TAG_W-1:0] exp_tag [$];
	logic [lsq_pkg::TAG_W-1:0] tag_next;
	logic load_seen;
	string cur_test;
	int errors;
	int test_errors;
	int tests;
	integer seed;

	lsq_top #(
		.N_WAY(N_WAY),
		.N_SQ(N_SQ),
		.MEM_WORDS(MEM_WORDS)
	) lsq_top_inst (
		.clock(clock),
		.reset(reset),
		.disp_count(disp_count),
		.alloc_pos(alloc_pos),
		.credits(credits),
		.ex_valid(ex_valid),
		.ex_pos(ex_pos),
		.ex_addr(ex_addr),
		.ex_data(ex_data),
		.ex_size(ex_size),
		.retire_count(retire_count),
		.flush(flush),
		.load_valid(load_valid),
		.load_addr(load_addr),
		.load_size(load_size),
		.load_unsigned(load_unsigned),
		.load_tag(load_tag),
		.load_older_count(load_older_count),
		.result_valid(result_valid),
		.result_data(result_data),
		.result_tag(result_tag),
		.result_forwarded(result_forwarded)
	);

	always #10 clock = ~clock;

	task automatic check_data(input string what, input logic [XLEN-1:0] exp,
			input logic [XLEN-1:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_count(input string what, input logic [$clog2(N_SQ):0] exp,
			input logic [$clog2(N_SQ):0] act);
		if (act !== exp) begin
			$display("CHECK FAILED %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_tag(input string what, input logic [lsq_pkg::TAG_W-1:0] exp,
			input logic [lsq_pkg::TAG_W-1:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
			errors++;
		end
	endtask

	// a load result is due exactly one edge after the load
	always @(posedge clock) begin
		load_seen <= load_valid;
	end

	// results are stable at the falling edge
	always @(negedge clock) begin
		if (!reset) begin
			check_flag("result valid", load_seen, result_valid);
		end
		if (!reset && result_valid) begin
			if (exp_data.size() == 0) begin
				$display("ERROR %s: load result arrived with no load outstanding", cur_test);
				errors++;
			end else begin
				check_data("load data", exp_data.pop_front(), result_data);
				check_flag("forwarded", exp_fwd.pop_front(), result_forwarded);
				check_tag("tag", exp_tag.pop_front(), result_tag);
			end
		end
	end

	task automatic idle_inputs();
		disp_count = '0;
		ex_valid = '0;
		ex_pos = '0;
		ex_addr = '0;
		ex_data = '0;
		ex_size = {N_WAY{lsq_pkg::BYTE}};
		retire_count = '0;
		flush = 1'b0;
		load_valid = 1'b0;
		load_addr = '0;
		load_size = lsq_pkg::BYTE;
		load_unsigned = 1'b0;
		load_tag = '0;
		load_older_count = '0;
	endtask

	task automatic next_cycle();
		@(negedge clock);
		idle_inputs();
	endtask

	// a load must be issued before other actions of the same cycle
	task automatic issue_load(input int addr, input lsq_pkg::mem_size_t size,
			input logic uns, input int older);
		logic fwd;
		logic [XLEN-1:0] v;
		v = expected_load(addr, size, uns, older, fwd);
		load_valid = 1'b1;
		load_addr = XLEN'(addr);
		load_size = size;
		load_unsigned = uns;
		load_tag = tag_next;
		load_older_count = ($clog2(N_SQ)+1)'(older);
		exp_data.push_back(v);
		exp_fwd.push_back(fwd);
		exp_tag.push_back(tag_next);
		tag_next++;
	endtask

	// partial overlap with an older store has no defined result
	task automatic load_if_defined(input int addr, input lsq_pkg::mem_size_t size,
			input logic uns, input int older);
		if (load_defined(addr, size, older))
			issue_load(addr, size, uns, older);
	endtask

	task automatic dispatch_stores(input int n);
		int p;
		if (n > int'(credits)) begin
			$display("ERROR %s: dispatch of %0d stores exceeds %0d credits", cur_test, n, credits);
			errors++;
		end
		if (n > 0)
			check_count("alloc_pos", ($clog2(N_SQ)+1)'(m_tail), {1'b0, alloc_pos});
		for (int i = 0; i < n; i++) begin
			p = (m_tail + i) % N_SQ;
			m_valid[p] = 1'b1;
			m_ex[p] = 1'b0;
		end
		m_tail = (m_tail + n) % N_SQ;
		m_count += n;
		disp_count = ($clog2(N_WAY)+1)'(n);
	endtask

	task automatic execute_store(input int way, input int pos, input int addr,
			input logic [XLEN-1:0] data, input lsq_pkg::mem_size_t size);
		ex_valid[way] = 1'b1;
		ex_pos[way] = $clog2(N_SQ)'(pos);
		ex_addr[way] = XLEN'(addr);
		ex_data[way] = data;
		ex_size[way] = size;
		m_ex[pos] = 1'b1;
		m_addr[pos] = XLEN'(addr);
		m_data[pos] = data;
		m_size[pos] = size;
	endtask

	task automatic retire_stores(input int n);
		int p;
		int sa;
		logic [31:0] sh;
		for (int i = 0; i < n; i++) begin
			p = m_head;
			sa = int'(m_addr[p]);
			for (int j = 0; j < size_bytes(m_size[p]); j++) begin
				sh = m_data[p] >> (8 * j);
				ref_mem[sa + j] = sh[7:0];
			end
			m_valid[p] = 1'b0;
			m_ex[p] = 1'b0;
			m_head = (m_head + 1) % N_SQ;
			m_count--;
		end
		retire_count = ($clog2(N_WAY)+1)'(n);
	endtask

	task automatic flush_queue();
		for (int p = 0; p < N_SQ; p++) begin
			m_valid[p] = 1'b0;
			m_ex[p] = 1'b0;
		end
		m_tail = m_head;
		m_count = 0;
		flush = 1'b1;
	endtask

	task automatic wait_results();
		int n;
		n = 0;
		while (exp_data.size() > 0 && n < 50) begin
			@(negedge clock);
			n++;
		end
		if (exp_data.size() > 0) begin
			$display("timeout in %s: %0d load results missing after 50 cycles", cur_test,
				exp_data.size());
			errors++;
			exp_data.delete();
			exp_fwd.delete();
			exp_tag.delete();
		end
	endtask

	task automatic end_test();
		wait_results();
		tests++;
		$display("test %s: %0d errors", cur_test, errors - test_errors);
		test_errors = errors;
	endtask

	// one store through dispatch, execute and retire
	task automatic store_now(input int addr, input logic [XLEN-1:0] data,
			input lsq_pkg::mem_size_t size);
		int p;
		p = m_tail;
		dispatch_stores(1);
		next_cycle();
		execute_store(0, p, addr, data, size);
		next_cycle();
		retire_stores(1);
		next_cycle();
	endtask

	task automatic load_all_ways(input int base, input int older);
		for (int o = 0; o < 4; o++) begin
			load_if_defined(base + o, lsq_pkg::BYTE, 1'b0, older);
			next_cycle();
			load_if_defined(base + o, lsq_pkg::BYTE, 1'b1, older);
			next_cycle();
		end
		for (int o = 0; o < 4; o += 2) begin
			load_if_defined(base + o, lsq_pkg::HALF, 1'b0, older);
			next_cycle();
			load_if_defined(base + o, lsq_pkg::HALF, 1'b1, older);
			next_cycle();
		end
		load_if_defined(base, lsq_pkg::WORD, 1'b0, older);
		next_cycle();
	endtask

	task automatic random_cycle();
		int n;
		int addr;
		int way;
		int p;
		lsq_pkg::mem_size_t sz;
		// load first, then retire, execute and dispatch
		if ($random(seed) % 2 == 0) begin
			sz = lsq_pkg::mem_size_t'($unsigned($random(seed)) % 3);
			addr = 224 + 4 * ($unsigned($random(seed)) % 4);
			addr += (sz == lsq_pkg::WORD) ? 0 : (sz == lsq_pkg::HALF) ?
				2 * ($unsigned($random(seed)) % 2) : $unsigned($random(seed)) % 4;
			n = $unsigned($random(seed)) % (m_count + 1);
			if (load_defined(addr, sz, n))
				issue_load(addr, sz, $random(seed) % 2 == 0, n);
		end
		if ($unsigned($random(seed)) % 40 == 0) begin
			flush_queue();
			return;
		end
		n = 0;
		while (n < N_WAY && n < m_count && m_ex[(m_head + n) % N_SQ])
			n++;
		retire_stores($unsigned($random(seed)) % (n + 1));
		way = 0;
		for (int k = 0; k < m_count && way < N_WAY; k++) begin
			p = (m_head + k) % N_SQ;
			if (m_valid[p] && !m_ex[p] && $random(seed) % 2 == 0) begin
				sz = lsq_pkg::mem_size_t'($unsigned($random(seed)) % 3);
				addr = 224 + 4 * ($unsigned($random(seed)) % 4);
				addr += (sz == lsq_pkg::WORD) ? 0 : (sz == lsq_pkg::HALF) ?
					2 * ($unsigned($random(seed)) % 2) : $unsigned($random(seed)) % 4;
				execute_store(way, p, addr, $random(seed), sz);
				way++;
			end
		end
		n = $unsigned($random(seed)) % (N_WAY + 1);
		if (n > int'(credits))
			n = int'(credits);
		dispatch_stores(n);
	endtask

	initial begin
		seed = 3;
		clock = 1'b0;
		reset = 1'b1;
		idle_inputs();
		errors = 0;
		test_errors = 0;
		tests = 0;
		tag_next = '0;
		m_head = 0;
		m_tail = 0;
		m_count = 0;
		for (int i = 0; i < MEM_WORDS * 4; i++)
			ref_mem[i] = 8'h00;
		for (int p = 0; p < N_SQ; p++) begin
			m_valid[p] = 1'b0;
			m_ex[p] = 1'b0;
		end
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		cur_test = "credits";
		check_count("credits after reset", ($clog2(N_SQ)+1)'(N_SQ), credits);
		dispatch_stores(2);
		next_cycle();
		check_count("credits after dispatch", ($clog2(N_SQ)+1)'(N_SQ - 2), credits);
		execute_store(0, 0, 0, 32'h11223344, lsq_pkg::WORD);
		execute_store(1, 1, 4, 32'h55667788, lsq_pkg::WORD);
		next_cycle();
		retire_stores(2);
		next_cycle();
		check_count("credits one edge after retire", ($clog2(N_SQ)+1)'(N_SQ - 2), credits);
		next_cycle();
		check_count("credits two edges after retire", ($clog2(N_SQ)+1)'(N_SQ), credits);
		end_test();

		cur_test = "retire";
		store_now(64, 32'h8a7b6c5d, lsq_pkg::WORD);
		store_now(65, 32'h000000f1, lsq_pkg::BYTE);
		store_now(68, 32'h0000c3d4, lsq_pkg::HALF);
		store_now(71, 32'h00000092, lsq_pkg::BYTE);
		store_now(74, 32'h0000e5a6, lsq_pkg::HALF);
		load_all_ways(64, 0);
		load_all_ways(68, 0);
		load_all_ways(72, 0);
		end_test();

		cur_test = "forwarding";
		dispatch_stores(2);
		next_cycle();
		execute_store(0, m_head, 128, 32'h8091a2b3, lsq_pkg::WORD);
		execute_store(1, (m_head + 1) % N_SQ, 134, 32'h0000f00d, lsq_pkg::HALF);
		next_cycle();
		load_all_ways(128, 2);
		load_all_ways(132, 2);
		retire_stores(2);
		next_cycle();
		end_test();

		cur_test = "program_order";
		dispatch_stores(2);
		next_cycle();
		dispatch_stores(2);
		next_cycle();
		for (int k = 0; k < 4; k += 2) begin
			execute_store(0, (m_head + k) % N_SQ, 192, 32'hc0de0000 + k, lsq_pkg::WORD);
			execute_store(1, (m_head + k + 1) % N_SQ, 192, 32'hc0de0001 + k, lsq_pkg::WORD);
			next_cycle();
		end
		for (int older = 0; older <= 4; older++) begin
			issue_load(192, lsq_pkg::WORD, 1'b0, older);
			next_cycle();
		end
		// retired stores stay visible to a load in the same cycle
		issue_load(194, lsq_pkg::HALF, 1'b1, 4);
		retire_stores(2);
		next_cycle();
		issue_load(192, lsq_pkg::WORD, 1'b0, 2);
		retire_stores(2);
		next_cycle();
		issue_load(192, lsq_pkg::WORD, 1'b0, 0);
		next_cycle();
		end_test();

		cur_test = "flush";
		dispatch_stores(2);
		next_cycle();
		execute_store(0, m_head, 192, 32'hdeadbeef, lsq_pkg::WORD);
		execute_store(1, (m_head + 1) % N_SQ, 64, 32'h0badcafe, lsq_pkg::WORD);
		next_cycle();
		flush_queue();
		next_cycle();
		next_cycle();
		check_count("credits after flush", ($clog2(N_SQ)+1)'(N_SQ), credits);
		issue_load(192, lsq_pkg::WORD, 1'b0, 0);
		next_cycle();
		issue_load(64, lsq_pkg::WORD, 1'b0, 0);
		next_cycle();
		end_test();

		cur_test = "random_mix";
		for (int c = 0; c < 400; c++) begin
			random_cycle();
			next_cycle();
		end
		flush_queue();
		next_cycle();
		next_cycle();
		check_count("credits after final flush", ($clog2(N_SQ)+1)'(N_SQ), credits);
		end_test();

		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: sim.f
+incdir+tb
design/lsq_pkg.sv
design/store_credit.sv
design/store_queue.sv
design/store_forward.sv
design/data_memory.sv
design/lsq_top.sv
tb/lsq_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the store queue simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sim.f --top-module lsq_tb -o lsq_sim

./obj_dir/lsq_sim > sim.log
cat sim.log

if grep -q "PASS: all tests" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
